//--- verilog/ps2kbd_pkg.sv
// widths, timer taps, keymap fields, PS/2 codes, controller states and shared types
package ps2kbd_pkg;

	//----------------------------------------
	// widths
	//----------------------------------------
	localparam int BYTE_W   = 8;		// one PS/2 data byte
	localparam int FRAME_W  = 12;		// start + 8 data + parity + stop + marker
	localparam int KEYMAP_W = 16;		// table entry
	localparam int ADDR_W   = BYTE_W + 1;	// extended flag on top of scan byte
	localparam int TIMER_W  = 20;

	// timer taps, at 7.09 MHz
	localparam int SHORT_TAP = 15;		// ~4.6 ms request-to-send hold
	localparam int LONG_TAP  = 19;		// ~74 ms idle / ack timeout

	//----------------------------------------
	// keymap word fields
	//----------------------------------------
	// amiga flags sit in the top byte
	localparam int KM_VALID   = 15;	// real amiga key
	localparam int KM_CTRL    = 14;
	localparam int KM_LALT    = 13;
	localparam int KM_RALT    = 12;
	localparam int KM_CAPS    = 11;
	localparam int KM_NUMLOCK = 10;
	localparam int KM_KEYPAD  = 9;	// only while num lock is off

	// bit 7 marks a PS/2 protocol byte, then bits 2:0 say which one
	localparam int KM_SPECIAL = 7;
	localparam int KM_EXT     = 0;	// E0
	localparam int KM_REL     = 1;	// F0
	localparam int KM_ACK     = 2;	// FA
	localparam int KM_CODE_HI = 6;	// amiga code in [6:0]

	//----------------------------------------
	// codes
	//----------------------------------------
	localparam logic [BYTE_W-1:0]  CMD_SET_LEDS = 8'hED;
	localparam logic [FRAME_W-1:0] FRAME_IDLE   = '1;		// receiver empty
	localparam logic [FRAME_W-1:0] SEND_DONE    = 12'h001;	// last stop bit gone

	// types
	typedef logic [BYTE_W-1:0]   ps2_byte_t;
	typedef logic [FRAME_W-1:0]  ps2_frame_t;
	typedef logic [BYTE_W-1:0]   amiga_key_t;	// bit 7 set on release
	typedef logic [KEYMAP_W-1:0] keymap_word_t;
	typedef logic [ADDR_W-1:0]   map_addr_t;
	typedef logic [TIMER_W-1:0]  ps2_timer_t;

	// keyboard controller FSM
	typedef enum logic [2:0]
	{
		timer_reset,	// hold clock low, clear timer
		rts_cmd,		// request to send ED
		send_cmd,		// ED going out, wait for ack byte
		rts_leds,		// request to send led byte
		send_leds,		// led byte going out, wait for ack byte
		wait_key,		// normal receive
		hold_key		// inhibit keyboard until key_ack
	} kbd_state_t;

endpackage

//--- verilog/ps2_line.sv
// PS/2 line synchronizer, clock edge detect, receive and send shifters, idle timer
`timescale 1ns/1ps

module ps2_line
(
	input	logic	clk,
	input	logic	reset,
	input	logic	ps2_kdat,		// raw data line
	input	logic	ps2_kclk,		// raw clock line
	input	logic	rx_clear,		// flush receiver
	input	logic	timer_clear,
	input	logic	load_cmd,		// load ED frame
	input	logic	load_leds,		// load led status frame
	input	logic	caps_lock,
	input	logic	num_lock,
	input	logic	led_scroll,
	output	ps2kbd_pkg::ps2_byte_t	rx_byte,
	output	logic	rx_ready,		// stop bit in, one cycle
	output	logic	rx_busy,		// start bit seen
	output	logic	tx_done,		// send shifter empty
	output	logic	ps2_kdat_out,
	output	logic	short_timeout,
	output	logic	long_timeout
);
	import ps2kbd_pkg::*;

	logic		dat_s;			// synced data
	logic		clk_s;			// synced clock
	logic		clk_d;			// clock one cycle older
	logic		clk_neg;		// falling edge of PS/2 clock
	ps2_frame_t	rx_shift;
	ps2_frame_t	tx_shift;
	ps2_timer_t	timer;
	ps2_byte_t	led_byte;

	//----------------------------------------
	// line sync
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		dat_s <= ps2_kdat;
		clk_s <= ps2_kclk;
		clk_d <= clk_s;
	end

	assign clk_neg = clk_d & ~clk_s;

	// receiver, start bit ends up in bit 0 when frame complete
	always_ff @(posedge clk)
		if (reset || rx_clear || rx_ready)
			rx_shift <= FRAME_IDLE;
		else if (clk_neg)
			rx_shift <= {1'b0, dat_s, rx_shift[FRAME_W-2:1]};

	assign rx_ready = ~rx_shift[0];
	assign rx_busy  = ~rx_shift[FRAME_W-1];
	assign rx_byte  = rx_shift[BYTE_W:1];	// skip start bit

	// idle timer, parks at the long tap
	always_ff @(posedge clk)
		if (reset || timer_clear)
			timer <= '0;
		else if (!long_timeout)
			timer <= timer + 1'b1;

	assign short_timeout = timer[SHORT_TAP];
	assign long_timeout  = timer[LONG_TAP];

	//----------------------------------------
	// send shifter
	//----------------------------------------
	assign led_byte = {{(BYTE_W-3){1'b0}}, caps_lock, num_lock, led_scroll};

	always_ff @(posedge clk)
		if (reset)
			tx_shift <= SEND_DONE;
		else if (load_cmd)
			tx_shift <= {2'b11, ~^CMD_SET_LEDS, CMD_SET_LEDS, 1'b0};	// odd parity
		else if (load_leds)
			tx_shift <= {2'b11, ~^led_byte, led_byte, 1'b0};
		else if (!tx_done && clk_neg)
			tx_shift <= {1'b0, tx_shift[FRAME_W-1:1]};	// next bit on each falling edge

	assign tx_done      = (tx_shift == SEND_DONE);
	assign ps2_kdat_out = tx_shift[0];	// start bit pulls data low during rts

endmodule

//--- verilog/kbd_controller.sv
// keyboard controller FSM: LED command sequence, key hand-off and clock inhibit
`timescale 1ns/1ps

module kbd_controller
(
	input	logic	clk,
	input	logic	reset,
	input	logic	rx_ready,
	input	logic	rx_busy,
	input	logic	tx_done,
	input	logic	short_timeout,
	input	logic	long_timeout,
	input	logic	key_strobe,		// new amiga key out
	input	logic	key_ack,		// host took it
	output	logic	rx_clear,
	output	logic	timer_clear,
	output	logic	load_cmd,
	output	logic	load_leds,
	output	logic	ps2_kclk_out	// 0 holds the clock low
);
	import ps2kbd_pkg::*;

	kbd_state_t	state;
	kbd_state_t	state_nxt;

	always_ff @(posedge clk)
		if (reset)
			state <= timer_reset;
		else
			state <= state_nxt;

	//----------------------------------------
	// next state and outputs
	//----------------------------------------
	always_comb
	begin
		rx_clear     = 1'b0;
		timer_clear  = 1'b0;
		load_cmd     = 1'b0;
		load_leds    = 1'b0;
		ps2_kclk_out = 1'b1;	// released by default
		state_nxt    = state;
		case (state)
			timer_reset:
			begin
				rx_clear     = 1'b1;
				timer_clear  = 1'b1;
				ps2_kclk_out = 1'b0;
				state_nxt    = rts_cmd;
			end
			rts_cmd:	// clock low, data low via start bit
			begin
				rx_clear     = 1'b1;
				load_cmd     = 1'b1;
				ps2_kclk_out = 1'b0;
				if (short_timeout)
					state_nxt = send_cmd;
			end
			send_cmd:
			begin
				rx_clear    = ~tx_done;	// open receiver for the ack
				timer_clear = 1'b1;
				if (rx_ready)
					state_nxt = rts_leds;
			end
			rts_leds:
			begin
				rx_clear     = 1'b1;
				load_leds    = 1'b1;
				ps2_kclk_out = 1'b0;
				if (short_timeout)
					state_nxt = send_leds;
			end
			send_leds:
			begin
				rx_clear    = ~tx_done;
				timer_clear = 1'b1;
				if (rx_ready)
					state_nxt = wait_key;
			end
			wait_key:
			begin
				timer_clear = key_strobe;	// restart for ack timeout
				if (key_strobe)
					state_nxt = hold_key;
				else if (!rx_busy && long_timeout)	// idle, refresh leds
					state_nxt = timer_reset;
			end
			hold_key:	// keyboard buffers meanwhile
			begin
				timer_clear  = key_ack;
				ps2_kclk_out = 1'b0;
				if (key_ack || long_timeout)
					state_nxt = wait_key;
			end
			default:
				state_nxt = timer_reset;
		endcase
	end

endmodule

//--- verilog/scancode_map.sv
// scan code set 2 to amiga key table, E0/F0 prefix tracking and num lock state
`timescale 1ns/1ps

module scancode_map
(
	input	logic	clk,
	input	logic	reset,
	input	logic	enable,			// new byte from receiver
	input	ps2kbd_pkg::ps2_byte_t	rx_byte,
	output	logic	map_valid,		// one cycle after enable
	output	ps2kbd_pkg::amiga_key_t	map_key,
	output	logic	is_ctrl,
	output	logic	is_lalt,
	output	logic	is_ralt,
	output	logic	is_caps,
	output	logic	num_lock
);
	import ps2kbd_pkg::*;

	keymap_word_t	km;			// registered table output
	map_addr_t		addr;
	logic			enable_d;	// table has one cycle latency
	logic			ext_seen;	// E0 received
	logic			break_seen;	// F0 received

	assign addr = {ext_seen, rx_byte};

	always_ff @(posedge clk)
		if (reset)
			enable_d <= 1'b0;
		else
			enable_d <= enable;

	// prefixes, ack byte leaves them alone
	always_ff @(posedge clk)
		if (reset)
		begin
			ext_seen   <= 1'b0;
			break_seen <= 1'b0;
		end
		else if (enable_d && km[KM_SPECIAL] && km[KM_EXT])
			ext_seen <= 1'b1;
		else if (enable_d && km[KM_SPECIAL] && km[KM_REL])
			break_seen <= 1'b1;
		else if (enable_d && !(km[KM_SPECIAL] && km[KM_ACK]))
		begin
			ext_seen   <= 1'b0;
			break_seen <= 1'b0;
		end

	always_ff @(posedge clk)
		if (reset)
			num_lock <= 1'b0;
		else if (enable_d && km[KM_NUMLOCK] && !break_seen)	// press only
			num_lock <= ~num_lock;

	assign map_valid = enable_d & km[KM_VALID] & (~km[KM_KEYPAD] | ~num_lock);
	assign map_key   = {break_seen, km[KM_CODE_HI:0]};
	assign is_ctrl   = km[KM_CTRL];
	assign is_lalt   = km[KM_LALT];
	assign is_ralt   = km[KM_RALT];
	assign is_caps   = km[KM_CAPS];

	//----------------------------------------
	// key table
	//----------------------------------------
	always_ff @(posedge clk)
		if (enable)
			case (addr)
				9'h015:	km <= 16'h8010;	// q
				9'h016:	km <= 16'h8001;	// 1
				9'h01a:	km <= 16'h8031;	// z
				9'h01b:	km <= 16'h8021;	// s
				9'h01c:	km <= 16'h8020;	// a
				9'h01d:	km <= 16'h8011;	// w
				9'h01e:	km <= 16'h8002;	// 2
				9'h021:	km <= 16'h8033;	// c
				9'h022:	km <= 16'h8032;	// x
				9'h023:	km <= 16'h8022;	// d
				9'h024:	km <= 16'h8012;	// e
				9'h025:	km <= 16'h8004;	// 4
				9'h026:	km <= 16'h8003;	// 3
				9'h029:	km <= 16'h8040;	// space
				9'h02a:	km <= 16'h8034;	// v
				9'h02b:	km <= 16'h8023;	// f
				9'h02c:	km <= 16'h8014;	// t
				9'h02d:	km <= 16'h8013;	// r
				9'h02e:	km <= 16'h8005;	// 5
				9'h031:	km <= 16'h8036;	// n
				9'h032:	km <= 16'h8035;	// b
				9'h033:	km <= 16'h8025;	// h
				9'h034:	km <= 16'h8024;	// g
				9'h035:	km <= 16'h8015;	// y
				9'h036:	km <= 16'h8006;	// 6
				9'h03a:	km <= 16'h8037;	// m
				9'h03b:	km <= 16'h8026;	// j
				9'h03c:	km <= 16'h8016;	// u
				9'h03d:	km <= 16'h8007;	// 7
				9'h03e:	km <= 16'h8008;	// 8
				9'h042:	km <= 16'h8027;	// k
				9'h043:	km <= 16'h8017;	// i
				9'h044:	km <= 16'h8018;	// o
				9'h045:	km <= 16'h800a;	// 0
				9'h046:	km <= 16'h8009;	// 9
				9'h04b:	km <= 16'h8028;	// l
				9'h04d:	km <= 16'h8019;	// p
				// modifiers
				9'h011:	km <= 16'ha064;	// left alt
				9'h012:	km <= 16'h8060;	// left shift
				9'h014:	km <= 16'hc063;	// ctrl
				9'h058:	km <= 16'h8862;	// caps lock
				9'h059:	km <= 16'h8061;	// right shift
				9'h077:	km <= 16'h0400;	// num lock, no amiga code
				9'h111:	km <= 16'h9065;	// right alt
				// keypad
				9'h069:	km <= 16'h821d;	// kp 1
				9'h06b:	km <= 16'h822d;	// kp 4
				9'h06c:	km <= 16'h823d;	// kp 7
				9'h070:	km <= 16'h820f;	// kp 0
				9'h071:	km <= 16'h823c;	// kp .
				9'h072:	km <= 16'h821e;	// kp 2
				9'h073:	km <= 16'h822e;	// kp 5
				9'h074:	km <= 16'h822f;	// kp 6
				9'h075:	km <= 16'h823e;	// kp 8
				9'h079:	km <= 16'h825e;	// kp +
				9'h07a:	km <= 16'h821f;	// kp 3
				9'h07b:	km <= 16'h824a;	// kp -
				9'h07c:	km <= 16'h825d;	// kp *
				9'h07d:	km <= 16'h823f;	// kp 9
				9'h14a:	km <= 16'h825c;	// kp /
				9'h15a:	km <= 16'h8243;	// kp enter
				// arrows
				9'h16b:	km <= 16'h804f;	// left
				9'h172:	km <= 16'h804d;	// down
				9'h174:	km <= 16'h804e;	// right
				9'h175:	km <= 16'h804c;	// up
				// protocol bytes, same with or without E0
				9'h0e0, 9'h1e0:	km <= 16'h0081;	// extended
				9'h0f0, 9'h1f0:	km <= 16'h0082;	// release
				9'h0fa, 9'h1fa:	km <= 16'h0084;	// ack
				default:	km <= '0;	// not mapped
			endcase

endmodule

//--- verilog/amiga_key_filter.sv
// typematic filter, amiga caps lock emulation, key strobe and reset combination detect
`timescale 1ns/1ps

module amiga_key_filter
(
	input	logic	clk,
	input	logic	reset,
	input	logic	map_valid,
	input	ps2kbd_pkg::amiga_key_t	map_key,
	input	logic	is_ctrl,
	input	logic	is_lalt,
	input	logic	is_ralt,
	input	logic	is_caps,
	output	logic	key_strobe,
	output	ps2kbd_pkg::amiga_key_t	key_data,
	output	logic	caps_lock,
	output	logic	kbd_reset
);
	import ps2kbd_pkg::*;

	amiga_key_t	last_key;		// last press, or its release
	logic		key_up;			// event is a release
	logic		key_equal;		// same key as latched
	logic		duplicate;		// same key, same direction
	logic [2:0]	rst_up;			// ctrl/caps, lalt, ralt released

	assign key_up    = map_key[7];
	assign key_equal = (last_key[6:0] == map_key[6:0]);
	assign duplicate = key_equal && (key_up == last_key[7]);

	//----------------------------------------
	// typematic filter
	//----------------------------------------
	always_ff @(posedge clk)
		if (reset)
			last_key <= '0;
		else if (map_valid && !key_up)	// any press
			last_key <= map_key;
		else if (map_valid && key_up && key_equal)	// release of latched key
			last_key <= map_key;

	// amiga keyboard remembers caps, toggle on each fresh press
	always_ff @(posedge clk)
		if (reset)
			caps_lock <= 1'b0;
		else if (map_valid && !key_up && is_caps && !duplicate)
			caps_lock <= ~caps_lock;

	// caps events hidden while caps lock set
	assign key_strobe = map_valid && !(caps_lock && is_caps) && !duplicate;
	assign key_data   = map_key;

	//----------------------------------------
	// reset combination
	//----------------------------------------
	always_ff @(posedge clk)
		if (reset)
			rst_up <= 3'b111;	// all keys up
		else
		begin
			if (map_valid && (is_ctrl || is_caps))
				rst_up[2] <= key_up;
			if (map_valid && is_lalt)
				rst_up[1] <= key_up;
			if (map_valid && is_ralt)
				rst_up[0] <= key_up;
		end

	assign kbd_reset = ~|rst_up;	// all three held

endmodule

//--- verilog/ps2_keyboard.sv
// PS/2 keyboard front end top level: line, controller, key map and key filter
`timescale 1ns/1ps

module ps2_keyboard
(
	input	logic	clk,
	input	logic	reset,
	input	logic	ps2_kdat,
	input	logic	ps2_kclk,
	input	logic	led_scroll,		// scroll lock led
	input	logic	key_ack,
	output	logic	ps2_kdat_out,	// 0 pulls data low
	output	logic	ps2_kclk_out,	// 0 pulls clock low
	output	ps2kbd_pkg::amiga_key_t	key_data,
	output	logic	key_strobe,
	output	logic	caps_lock,
	output	logic	kbd_reset
);
	import ps2kbd_pkg::*;

	// line <-> controller
	logic		rx_ready, rx_busy, tx_done;
	logic		short_timeout, long_timeout;
	logic		rx_clear, timer_clear, load_cmd, load_leds;
	ps2_byte_t	rx_byte;
	// map -> filter
	logic		map_valid, is_ctrl, is_lalt, is_ralt, is_caps, num_lock;
	amiga_key_t	map_key;

	ps2_line u_line (
		.clk, .reset, .ps2_kdat, .ps2_kclk,
		.rx_clear, .timer_clear, .load_cmd, .load_leds,
		.caps_lock, .num_lock, .led_scroll,
		.rx_byte, .rx_ready, .rx_busy, .tx_done, .ps2_kdat_out,
		.short_timeout, .long_timeout
	);

	kbd_controller u_ctrl (
		.clk, .reset, .rx_ready, .rx_busy, .tx_done,
		.short_timeout, .long_timeout, .key_strobe, .key_ack,
		.rx_clear, .timer_clear, .load_cmd, .load_leds, .ps2_kclk_out
	);

	// table lookup on each received byte
	scancode_map u_map (
		.clk, .reset, .enable(rx_ready), .rx_byte,
		.map_valid, .map_key, .is_ctrl, .is_lalt, .is_ralt, .is_caps, .num_lock
	);

	amiga_key_filter u_filter (
		.clk, .reset, .map_valid, .map_key,
		.is_ctrl, .is_lalt, .is_ralt, .is_caps,
		.key_strobe, .key_data, .caps_lock, .kbd_reset
	);

endmodule

//--- verif/ps2_device_model.svh
// keyboard side of the PS/2 link: frame sender, host command receiver, bus settle wait
`ifndef PS2_DEVICE_MODEL_SVH
`define PS2_DEVICE_MODEL_SVH

	// idle wait in system clocks
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// device to host frame: start, 8 data lsb first, odd parity, stop
	task automatic send_frame(input ps2_byte_t data);
		logic [10:0] bits;
		int i;
		bits = {1'b1, ~^data, data, 1'b0};
		while (!ps2_kclk_out)	// host inhibits, keyboard buffers
			@(posedge clk);
		#1;
		for (i = 0; i < 11; i++)
		begin
			dev_dat = bits[i];
			wait_cycles(HALF_BIT);
			dev_clk = 1'b0;		// DUT samples on this edge
			wait_cycles(HALF_BIT);
			dev_clk = 1'b1;
		end
		dev_dat = 1'b1;
	endtask

	// let a pending strobe start its hold, then wait for the release
	task automatic settle_bus();
		wait_cycles(8);
		while (!ps2_kclk_out)
			@(posedge clk);
		#1;
	endtask

	//----------------------------------------
	// host to device command
	//----------------------------------------
	task automatic receive_command(input string name, output ps2_byte_t data);
		logic [10:0] bits;
		int i;
		while (ps2_kclk_out)	// wait for request to send
			@(posedge clk);
		while (!ps2_kclk_out)
			@(posedge clk);
		#1;
		check_bit({name, " start bit"}, 1'b0, ps2_kdat_out);
		for (i = 0; i < 11; i++)
		begin
			bits[i] = ps2_kdat_out;	// read while clock high
			wait_cycles(HALF_BIT);
			dev_clk = 1'b0;
			wait_cycles(HALF_BIT);
			dev_clk = 1'b1;
		end
		data = bits[8:1];
		check_bit({name, " parity"}, 1'b1, ^bits[9:1]);	// odd over data+parity
		check_bit({name, " stop bit"}, 1'b1, bits[10]);
		wait_cycles(2*HALF_BIT);
		send_frame(8'hFA);	// acknowledge
	endtask

`endif

//--- verif/tb_ps2_keyboard.sv
// PS/2 keyboard front end testbench with clock, reset, ack responder, key table and checks
`timescale 1ns/1ps

module tb_ps2_keyboard;
	import ps2kbd_pkg::*;

	localparam int HALF_BIT     = 5;	// PS/2 half clock, in system clocks
	localparam int NUM_TESTS    = 29;
	localparam int FRAME_CYCLES = 22*HALF_BIT + 60;
	localparam int TIMEOUT      = 4*(2**SHORT_TAP) + (NUM_TESTS*3 + 4)*FRAME_CYCLES;

	logic		clk, reset, led_scroll, key_ack;
	logic		dev_clk, dev_dat;	// keyboard side open collector drives
	logic		ps2_kdat_out, ps2_kclk_out, key_strobe, caps_lock, kbd_reset;
	amiga_key_t	key_data;
	amiga_key_t	strobes[$];		// codes seen since last entry
	logic [15:0]	lfsr;
	int			ack_delay;
	int unsigned	cycle_count;
	// row fields bytes[38:15] len[14:11] strobe[10] key[9:2] caps[1] kbd_reset[0]
	logic [38:0]	stim_table [NUM_TESTS];

	ps2_keyboard DUT (
		.clk, .reset,
		.ps2_kdat(dev_dat & ps2_kdat_out),	// wired-and lines
		.ps2_kclk(dev_clk & ps2_kclk_out),
		.led_scroll, .key_ack,
		.ps2_kdat_out, .ps2_kclk_out, .key_data, .key_strobe, .caps_lock, .kbd_reset
	);

	//----------------------------------------
	// compare tasks
	//----------------------------------------
	task automatic check_key(input string name, input amiga_key_t exp, input amiga_key_t act);
		if (exp !== act)
		begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_byte(input string name, input ps2_byte_t exp, input ps2_byte_t act);
		if (exp !== act)
		begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	`include "ps2_device_model.svh"

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT)
		begin
			$display("timeout, the DUT stopped responding");
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// host side records each strobe and acks after 0..15 cycles
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (key_strobe)
			begin
				strobes.push_back(key_data);
				ack_delay = 0;
				repeat (4)
				begin
					lfsr = lfsr_next(lfsr);	// one step per bit
					ack_delay = ack_delay*2 + int'(lfsr[0]);
				end
				repeat (ack_delay) @(posedge clk);
				@(posedge clk);
				#1;
				check_bit("keyboard inhibit before ack", 1'b0, ps2_kclk_out);	// held until ack
				key_ack = 1'b1;
				@(posedge clk) #1 key_ack = 1'b0;
			end
		end
	end

	//----------------------------------------
	// main sequence
	//----------------------------------------
	initial
	begin : main
		ps2_byte_t	rx;
		logic [38:0]	row;
		string		name;
		stim_table = '{
			{8'h1c, 8'h00, 8'h00, 4'd1, 1'b1, 8'h20, 1'b0, 1'b0},	// a
			{8'hf0, 8'h1c, 8'h00, 4'd2, 1'b1, 8'ha0, 1'b0, 1'b0},
			{8'h15, 8'h00, 8'h00, 4'd1, 1'b1, 8'h10, 1'b0, 1'b0},	// q
			{8'h15, 8'h00, 8'h00, 4'd1, 1'b0, 8'h00, 1'b0, 1'b0},	// repeat dropped
			{8'hf0, 8'h15, 8'h00, 4'd2, 1'b1, 8'h90, 1'b0, 1'b0},
			{8'h16, 8'h00, 8'h00, 4'd1, 1'b1, 8'h01, 1'b0, 1'b0},	// 1
			{8'hf0, 8'h16, 8'h00, 4'd2, 1'b1, 8'h81, 1'b0, 1'b0},
			{8'h29, 8'h00, 8'h00, 4'd1, 1'b1, 8'h40, 1'b0, 1'b0},	// space
			{8'hf0, 8'h29, 8'h00, 4'd2, 1'b1, 8'hc0, 1'b0, 1'b0},
			{8'he0, 8'h75, 8'h00, 4'd2, 1'b1, 8'h4c, 1'b0, 1'b0},	// up arrow
			{8'he0, 8'hf0, 8'h75, 4'd3, 1'b1, 8'hcc, 1'b0, 1'b0},
			{8'h58, 8'h00, 8'h00, 4'd1, 1'b1, 8'h62, 1'b1, 1'b0},	// caps on
			{8'hf0, 8'h58, 8'h00, 4'd2, 1'b0, 8'h00, 1'b1, 1'b0},
			{8'h58, 8'h00, 8'h00, 4'd1, 1'b0, 8'h00, 1'b0, 1'b0},	// caps off
			{8'hf0, 8'h58, 8'h00, 4'd2, 1'b1, 8'he2, 1'b0, 1'b0},
			{8'h75, 8'h00, 8'h00, 4'd1, 1'b1, 8'h3e, 1'b0, 1'b0},	// kp 8
			{8'hf0, 8'h75, 8'h00, 4'd2, 1'b1, 8'hbe, 1'b0, 1'b0},
			{8'h77, 8'h00, 8'h00, 4'd1, 1'b0, 8'h00, 1'b0, 1'b0},	// num lock
			{8'h75, 8'h00, 8'h00, 4'd1, 1'b0, 8'h00, 1'b0, 1'b0},	// kp gated
			{8'hf0, 8'h77, 8'h00, 4'd2, 1'b0, 8'h00, 1'b0, 1'b0},
			{8'hf0, 8'h75, 8'h00, 4'd2, 1'b0, 8'h00, 1'b0, 1'b0},
			{8'h14, 8'h00, 8'h00, 4'd1, 1'b1, 8'h63, 1'b0, 1'b0},	// ctrl
			{8'h11, 8'h00, 8'h00, 4'd1, 1'b1, 8'h64, 1'b0, 1'b0},	// left alt
			{8'he0, 8'h11, 8'h00, 4'd2, 1'b1, 8'h65, 1'b0, 1'b1},	// right alt, reset
			{8'hf0, 8'h11, 8'h00, 4'd2, 1'b1, 8'he4, 1'b0, 1'b0},
			{8'h11, 8'h00, 8'h00, 4'd1, 1'b1, 8'h64, 1'b0, 1'b1},
			{8'he0, 8'hf0, 8'h11, 4'd3, 1'b1, 8'he5, 1'b0, 1'b0},
			{8'he0, 8'h11, 8'h00, 4'd2, 1'b1, 8'h65, 1'b0, 1'b1},	// right alt again
			{8'hf0, 8'h14, 8'h00, 4'd2, 1'b1, 8'he3, 1'b0, 1'b0}	// ctrl up drops reset
		};
		reset       = 1'b1;
		led_scroll  = 1'b1;
		key_ack     = 1'b0;
		dev_clk     = 1'b1;
		dev_dat     = 1'b1;
		lfsr        = 16'd11295;
		cycle_count = 0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		check_bit("key_strobe after reset", 1'b0, key_strobe);
		check_bit("caps_lock after reset", 1'b0, caps_lock);
		check_bit("kbd_reset after reset", 1'b0, kbd_reset);
		check_bit("clock inhibit after reset", 1'b0, ps2_kclk_out);

		// ED first, led byte carries scroll only
		receive_command("led command", rx);
		check_byte("led command", 8'hED, rx);
		receive_command("led byte", rx);
		check_byte("led byte", 8'h01, rx);

		for (int i = 0; i < NUM_TESTS; i++)
		begin
			row  = stim_table[i];
			name = $sformatf("entry %0d", i);
			strobes.delete();
			for (int j = 0; j < int'(row[14:11]); j++)
			begin
				send_frame(row[38-8*j -: 8]);
				settle_bus();
			end
			if (row[10])
			begin
				check_bit({name, " one strobe"}, 1'b1, strobes.size() == 1);
				check_key(name, row[9:2], strobes[0]);
			end
			else
				check_bit({name, " no strobe"}, 1'b1, strobes.size() == 0);
			check_bit({name, " caps_lock"}, row[1], caps_lock);
			check_bit({name, " kbd_reset"}, row[0], kbd_reset);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verif
verilog/ps2kbd_pkg.sv
verilog/ps2_line.sv
verilog/kbd_controller.sv
verilog/scancode_map.sv
verilog/amiga_key_filter.sv
verilog/ps2_keyboard.sv
verif/tb_ps2_keyboard.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard verilog/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
